// File: filelist.f
+incdir+hdl
hdl/core_pkg.sv
hdl/regfile_if.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/shift_counter.sv
hdl/exec_ctrl.sv
hdl/exec_core.sv
test/tb_exec_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_exec_core
RTL_TOP ?= exec_core
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "tests failed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/100ps -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_exec_core.sv
`timescale 1ns/100ps
`default_nettype none
`include "core_consts.svh"

module tb_exec_core;
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic rst;
	logic instr_valid;
	logic instr_ready;
	logic [`DATA_W-1:0] instr;
	logic res_valid;
	logic res_ready;
	logic [`ADDR_W-1:0] res_dest;
	logic [`DATA_W-1:0] res_data;
	logic [`CCR_W-1:0] res_flags;
	logic [`PC_W-1:0] pc;

	// reference model of the architectural state
	logic [`DATA_W-1:0] m_regs [0:`NUM_REGS-1];
	logic [`PC_W-1:0] m_sp;
	logic [`CCR_W-1:0] m_ccr;
	logic [`PC_W-1:0] m_pc;

	// last accepted result beat
	logic [`ADDR_W-1:0] got_dest;
	logic [`DATA_W-1:0] got_data;
	logic [`CCR_W-1:0] got_flags;

	int errors;
	int checks;
	int seed;
	int stall_cycles;
	logic timed_out;
	string test_name;

	exec_core i_exec_core (
		.clk(clk),
		.rst(rst),
		.instr_valid(instr_valid),
		.instr_ready(instr_ready),
		.instr(instr),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res_dest(res_dest),
		.res_data(res_data),
		.res_flags(res_flags),
		.pc(pc)
	);

	always #5 clk = ~clk;

	function automatic logic [`DATA_W-1:0] enc_reg(logic [3:0] op, logic [2:0] rd,
		logic [2:0] rs1, logic [2:0] rs2);
		return {op, rd, rs1, rs2, 3'b000};
	endfunction

	function automatic logic [`DATA_W-1:0] enc_imm(logic [3:0] op, logic [2:0] rd,
		logic [7:0] imm);
		return {op, rd, 1'b0, imm};
	endfunction

	// a stuck handshake ends all further traffic
	task automatic report_timeout(string msg);
		errors++;
		timed_out = 1'b1;
		$display("%s in test %s", msg, test_name);
	endtask

	task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
		checks++;
		assert (exp == act) else begin
			errors++;
			$display("ERROR %s: %s expected %0h actual %0h", test_name, what, exp, act);
		end
	endtask

	task automatic send_instr(logic [`DATA_W-1:0] word);
		int waited;
		waited = 0;
		@(posedge clk);
		instr_valid <= 1'b1;
		instr <= word;
		@(negedge clk);
		// ready seen at negedge means the next edge transfers
		while (!instr_ready && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!instr_ready) begin
			report_timeout("instr_ready never came high");
		end else begin
			@(posedge clk);
			instr_valid <= 1'b0;
		end
	endtask

	task automatic get_result(logic stall);
		int waited;
		logic got;
		logic seen;
		logic [`ADDR_W-1:0] held_dest;
		logic [`DATA_W-1:0] held_data;
		logic [`CCR_W-1:0] held_flags;
		waited = 0;
		got = 1'b0;
		seen = 1'b0;
		while (!got && waited < WAIT_LIMIT) begin
			@(posedge clk);
			// ready high about one cycle in four when stalling
			if (stall) begin
				res_ready <= (($random(seed) & 3) == 0);
			end else begin
				res_ready <= 1'b1;
			end
			@(negedge clk);
			if (res_valid) begin
				// beat must not move while held off
				if (seen) begin
					check_value("held res_dest", 32'(held_dest), 32'(res_dest));
					check_value("held res_data", 32'(held_data), 32'(res_data));
					check_value("held res_flags", 32'(held_flags), 32'(res_flags));
				end
				if (res_ready) begin
					got_dest = res_dest;
					got_data = res_data;
					got_flags = res_flags;
					got = 1'b1;
				end else begin
					seen = 1'b1;
					held_dest = res_dest;
					held_data = res_data;
					held_flags = res_flags;
					stall_cycles++;
					// nothing retires before the handshake
					check_value("pc during stall", m_pc, pc);
				end
			end
			waited++;
		end
		if (!got) begin
			report_timeout("no result beat arrived");
		end else begin
			// handshake edge
			@(posedge clk);
			res_ready <= 1'b0;
		end
	endtask

	task automatic check_result(logic [`DATA_W-1:0] word);
		logic [3:0] op;
		logic [2:0] rd;
		logic [2:0] rs1;
		logic [2:0] rs2;
		logic [7:0] imm;
		logic [`DATA_W-1:0] val;
		logic [`PC_W-1:0] new_sp;
		logic [`CCR_W-1:0] flags;
		logic carry;
		logic write_rd;
		logic set_flags;
		int sum;
		int amount;
		op = word[15:12];
		rd = word[11:9];
		rs1 = word[8:6];
		rs2 = word[5:3];
		imm = word[7:0];
		val = '0;
		carry = 1'b0;
		write_rd = 1'b1;
		set_flags = 1'b1;
		new_sp = m_sp;
		amount = int'(imm[3:0]);
		case (op)
			`OP_ADD: begin
				sum = int'(m_regs[rs1]) + int'(m_regs[rs2]);
				val = sum[15:0];
				carry = (sum > 65535);
			end
			`OP_SUB: begin
				sum = int'(m_regs[rs1]) - int'(m_regs[rs2]);
				val = sum[15:0];
				carry = (m_regs[rs1] < m_regs[rs2]);
			end
			`OP_AND: val = m_regs[rs1] & m_regs[rs2];
			`OP_OR: val = m_regs[rs1] | m_regs[rs2];
			`OP_LDI: begin
				val = {8'h00, imm};
				set_flags = 1'b0;
			end
			`OP_SHL: begin
				val = m_regs[rd] << amount;
				if (amount != 0) begin
					carry = m_regs[rd][16 - amount];
				end
			end
			`OP_SHR: begin
				val = m_regs[rd] >> amount;
				if (amount != 0) begin
					carry = m_regs[rd][amount - 1];
				end
			end
			`OP_SPADD: begin
				new_sp = m_sp + (imm[7] ? {24'hffffff, imm} : {24'h000000, imm});
				val = new_sp[15:0];
				write_rd = 1'b0;
				set_flags = 1'b0;
			end
			default: begin
				write_rd = 1'b0;
				set_flags = 1'b0;
			end
		endcase
		flags = m_ccr;
		if (set_flags) begin
			flags[`FLAG_Z] = (val == 16'h0000);
			flags[`FLAG_N] = val[15];
			flags[`FLAG_C] = carry;
		end
		check_value("res_dest", 32'(write_rd ? rd : 3'd0), 32'(got_dest));
		check_value("res_data", 32'(val), 32'(got_data));
		check_value("res_flags", 32'(flags), 32'(got_flags));
		// retire into the model
		if (write_rd) begin
			m_regs[rd] = val;
		end
		m_ccr = flags;
		m_sp = new_sp;
		m_pc = m_pc + 1;
	endtask

	task automatic run_op(logic [`DATA_W-1:0] word, logic stall);
		if (!timed_out) begin
			send_instr(word);
		end
		if (!timed_out) begin
			get_result(stall);
		end
		if (!timed_out) begin
			check_result(word);
			@(negedge clk);
			check_value("pc", m_pc, pc);
		end
	endtask

	task automatic verify_reset();
		test_name = "reset";
		@(negedge clk);
		check_value("pc", 32'h0, pc);
		run_op(enc_imm(`OP_SPADD, 3'd0, 8'h00), 1'b0);
		run_op(enc_reg(`OP_ADD, 3'd1, 3'd0, 3'd0), 1'b0);
	endtask

	task automatic exercise_alu();
		test_name = "alu";
		run_op(enc_imm(`OP_LDI, 3'd1, 8'hff), 1'b0);
		run_op(enc_imm(`OP_LDI, 3'd2, 8'h01), 1'b0);
		run_op(enc_imm(`OP_LDI, 3'd3, 8'h80), 1'b0);
		run_op(enc_reg(`OP_ADD, 3'd4, 3'd1, 3'd2), 1'b0);
		// build 0xffff for the carry case
		run_op(enc_imm(`OP_LDI, 3'd5, 8'hff), 1'b0);
		run_op(enc_imm(`OP_SHL, 3'd5, 8'h08), 1'b0);
		run_op(enc_reg(`OP_OR, 3'd5, 3'd5, 3'd1), 1'b0);
		run_op(enc_reg(`OP_ADD, 3'd6, 3'd5, 3'd2), 1'b0);
		// borrow, then a zero difference
		run_op(enc_reg(`OP_SUB, 3'd7, 3'd2, 3'd1), 1'b0);
		run_op(enc_reg(`OP_SUB, 3'd4, 3'd1, 3'd1), 1'b0);
		run_op(enc_reg(`OP_AND, 3'd4, 3'd5, 3'd3), 1'b0);
		run_op(enc_reg(`OP_AND, 3'd6, 3'd3, 3'd2), 1'b0);
		run_op(enc_reg(`OP_OR, 3'd7, 3'd3, 3'd2), 1'b0);
	endtask

	task automatic sweep_shifts();
		test_name = "shifts";
		run_op(enc_imm(`OP_LDI, 3'd3, 8'ha5), 1'b0);
		run_op(enc_imm(`OP_SHL, 3'd3, 8'h00), 1'b0);
		run_op(enc_imm(`OP_SHL, 3'd3, 8'h01), 1'b0);
		// upper imm bits are not part of the amount
		run_op(enc_imm(`OP_SHL, 3'd3, 8'hf5), 1'b0);
		run_op(enc_imm(`OP_SHL, 3'd3, 8'h0f), 1'b0);
		run_op(enc_imm(`OP_LDI, 3'd3, 8'hc3), 1'b0);
		run_op(enc_imm(`OP_SHL, 3'd3, 8'h08), 1'b0);
		run_op(enc_imm(`OP_SHR, 3'd3, 8'h00), 1'b0);
		run_op(enc_imm(`OP_SHR, 3'd3, 8'h01), 1'b0);
		run_op(enc_imm(`OP_SHR, 3'd3, 8'h05), 1'b0);
		run_op(enc_imm(`OP_SHL, 3'd5, 8'h00), 1'b0);
		run_op(enc_imm(`OP_SHR, 3'd5, 8'h0f), 1'b0);
	endtask

	task automatic stall_results();
		logic [`PC_W-1:0] start_pc;
		test_name = "backpressure";
		stall_cycles = 0;
		start_pc = m_pc;
		run_op(enc_reg(`OP_ADD, 3'd4, 3'd1, 3'd2), 1'b1);
		run_op(enc_reg(`OP_SUB, 3'd6, 3'd4, 3'd1), 1'b1);
		run_op(enc_imm(`OP_SHL, 3'd6, 8'h03), 1'b1);
		run_op(enc_imm(`OP_LDI, 3'd2, 8'h5a), 1'b1);
		run_op(enc_imm(`OP_SPADD, 3'd0, 8'h02), 1'b1);
		run_op(enc_reg(`OP_NOP, 3'd0, 3'd0, 3'd0), 1'b1);
		run_op(enc_reg(`OP_OR, 3'd7, 3'd2, 3'd6), 1'b1);
		// seven retires, each counted once
		check_value("pc after stalls", start_pc + 32'd7, pc);
		checks++;
		assert (stall_cycles > 0) else begin
			errors++;
			$display("no back-pressure cycle was applied in test %s", test_name);
		end
	endtask

	task automatic adjust_sp_and_retire_nops();
		test_name = "spadd_nop";
		// negative adjust drops below the reset value
		run_op(enc_imm(`OP_SPADD, 3'd0, 8'hf0), 1'b0);
		run_op(enc_imm(`OP_SPADD, 3'd0, 8'h7f), 1'b0);
		// nop with a nonzero rd field, then read rd back
		run_op(16'h0e3f, 1'b0);
		run_op(enc_reg(`OP_OR, 3'd4, 3'd7, 3'd7), 1'b0);
		// undefined opcode aimed at r2
		run_op(16'hc5ff, 1'b0);
		run_op(enc_reg(`OP_OR, 3'd4, 3'd2, 3'd2), 1'b0);
		run_op(16'hf000, 1'b0);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		res_ready = 1'b0;
		errors = 0;
		checks = 0;
		stall_cycles = 0;
		timed_out = 1'b0;
		seed = 32'hd05c;
		test_name = "init";
		for (int i = 0; i < `NUM_REGS; i++) begin
			m_regs[i] = '0;
		end
		m_sp = `SP_RESET;
		m_ccr = '0;
		m_pc = '0;
		repeat (3) @(posedge clk);
		// both handshakes quiet while reset is held
		@(negedge clk);
		test_name = "reset";
		check_value("instr_ready in reset", 32'h0, 32'(instr_ready));
		check_value("res_valid in reset", 32'h0, 32'(res_valid));
		@(posedge clk);
		rst <= 1'b0;

		verify_reset();
		exercise_alu();
		sweep_shifts();
		stall_results();
		adjust_sp_and_retire_nops();

		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/exec_core.sv
`timescale 1ns/100ps
`default_nettype none
`include "core_consts.svh"

module exec_core (
	input wire logic clk,
	input wire logic rst,
	input wire logic instr_valid,
	output logic instr_ready,
	input wire logic [`DATA_W-1:0] instr,
	output logic res_valid,
	input wire logic res_ready,
	output logic [`ADDR_W-1:0] res_dest,
	output logic [`DATA_W-1:0] res_data,
	output logic [`CCR_W-1:0] res_flags,
	output logic [`PC_W-1:0] pc
);
	// alu hookup
	logic [`OP_W-1:0] alu_op;
	logic [`DATA_W-1:0] alu_a;
	logic [`DATA_W-1:0] alu_b;
	logic [`IMM_W-1:0] alu_imm;
	logic [`DATA_W-1:0] alu_result;
	logic [`PC_W-1:0] alu_sp;
	logic [`CCR_W-1:0] alu_flags;
	// shift pacing
	logic cnt_load;
	logic [`SHAMT_W-1:0] cnt_amount;
	logic cnt_step;
	logic cnt_done;

	regfile_if rf_bus ();

	reg_file i_reg_file (
		.clk(clk),
		.rst(rst),
		.rf(rf_bus.rf),
		.pc(pc)
	);

	// sp and flags come straight from the register file
	alu i_alu (
		.op(alu_op),
		.a(alu_a),
		.b(alu_b),
		.sp_in(rf_bus.sp),
		.imm(alu_imm),
		.flags_in(rf_bus.ccr),
		.shift_step(cnt_step),
		.result(alu_result),
		.sp_out(alu_sp),
		.flags_out(alu_flags)
	);

	shift_counter i_shift_counter (
		.clk(clk),
		.rst(rst),
		.load(cnt_load),
		.amount(cnt_amount),
		.step(cnt_step),
		.done(cnt_done)
	);

	exec_ctrl i_exec_ctrl (
		.clk(clk),
		.rst(rst),
		.instr_valid(instr_valid),
		.instr_ready(instr_ready),
		.instr(instr),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res_dest(res_dest),
		.res_data(res_data),
		.res_flags(res_flags),
		.rf(rf_bus.ctrl),
		.alu_op(alu_op),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.alu_imm(alu_imm),
		.alu_result(alu_result),
		.alu_sp(alu_sp),
		.alu_flags(alu_flags),
		.cnt_load(cnt_load),
		.cnt_amount(cnt_amount),
		.cnt_done(cnt_done)
	);

endmodule

`default_nettype wire

// File: hdl/exec_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "core_consts.svh"

module exec_ctrl (
	input wire logic clk,
	input wire logic rst,
	input wire logic instr_valid,
	output logic instr_ready,
	input wire core_pkg::instr_word_t instr,
	output logic res_valid,
	input wire logic res_ready,
	output logic [`ADDR_W-1:0] res_dest,
	output logic [`DATA_W-1:0] res_data,
	output logic [`CCR_W-1:0] res_flags,
	regfile_if.ctrl rf,
	output logic [`OP_W-1:0] alu_op,
	output logic [`DATA_W-1:0] alu_a,
	output logic [`DATA_W-1:0] alu_b,
	output logic [`IMM_W-1:0] alu_imm,
	input wire logic [`DATA_W-1:0] alu_result,
	input wire logic [`PC_W-1:0] alu_sp,
	input wire logic [`CCR_W-1:0] alu_flags,
	output logic cnt_load,
	output logic [`SHAMT_W-1:0] cnt_amount,
	input wire logic cnt_done
);
	import core_pkg::*;

	ctrl_state_t state;
	instr_word_t instr_q;
	logic [`DATA_W-1:0] a_q;
	logic [`DATA_W-1:0] b_q;
	logic [`DATA_W-1:0] data_q;
	logic [`CCR_W-1:0] flags_q;
	logic [`PC_W-1:0] sp_q;
	logic [`OP_W-1:0] opcode;
	logic is_shift;
	logic writes_rd;
	logic sets_flags;
	logic is_spadd;
	logic commit;

	// decode of the held word
	assign opcode = instr_q.r.opcode;
	assign is_shift = (opcode == `OP_SHL) || (opcode == `OP_SHR);
	// add through shr all land in rd
	assign writes_rd = (opcode >= `OP_ADD) && (opcode <= `OP_SHR);
	assign sets_flags = writes_rd && (opcode != `OP_LDI);
	assign is_spadd = (opcode == `OP_SPADD);

	// handshakes, both quiet while reset is held
	assign instr_ready = (state == IDLE) && !rst;
	assign res_valid = (state == RESP);
	assign commit = res_valid && res_ready;

	// shifts work on rd in place
	assign rf.ra1 = is_shift ? instr_q.i.rd : instr_q.r.rs1;
	assign rf.ra2 = instr_q.r.rs2;

	assign alu_op = opcode;
	assign alu_a = a_q;
	assign alu_b = b_q;
	assign alu_imm = instr_q.i.imm;

	// counter armed in READ so EXEC lasts max(n,1) cycles
	assign cnt_load = (state == READ) && is_shift;
	assign cnt_amount = instr_q.i.imm[`SHAMT_W-1:0];

	// result beat, all from held registers
	assign res_dest = writes_rd ? instr_q.r.rd : '0;
	assign res_data = data_q;
	assign res_flags = flags_q;

	// every write waits for the result handshake
	assign rf.we = commit && writes_rd;
	assign rf.waddr = instr_q.r.rd;
	assign rf.wdata = data_q;
	assign rf.ccr_we = commit && sets_flags;
	assign rf.ccr_wdata = flags_q;
	assign rf.sp_we = commit && is_spadd;
	assign rf.sp_wdata = sp_q;
	assign rf.pc_inc = commit;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (instr_valid) state <= READ;
				READ: state <= EXEC;
				// non-shift ops take a single cycle here
				EXEC: if (!is_shift || cnt_done) state <= RESP;
				RESP: if (res_ready) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (instr_ready && instr_valid) begin
			instr_q <= instr;
		end
		if (state == READ) begin
			a_q <= rf.rd1;
			b_q <= rf.rd2;
		end
		// shifted value loops back for the next step
		if (state == EXEC) begin
			a_q <= alu_result;
			data_q <= alu_result;
			flags_q <= alu_flags;
			sp_q <= alu_sp;
		end
	end

	// result beat frozen under back-pressure
	a_resp_stable: assert property (
		@(posedge clk) disable iff (rst)
		res_valid && !res_ready |=>
			res_valid && $stable(res_dest) && $stable(res_data) && $stable(res_flags)
	);

endmodule

`default_nettype wire

// File: hdl/shift_counter.sv
`timescale 1ns/100ps
`default_nettype none
`include "core_consts.svh"

module shift_counter (
	input wire logic clk,
	input wire logic rst,
	input wire logic load,
	input wire logic [`SHAMT_W-1:0] amount,
	output logic step,
	output logic done
);
	// remaining shift steps
	logic [`SHAMT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (load) begin
			count <= amount;
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// one bit moves per nonzero cycle
	assign step = (count != '0);
	// last step this cycle, or nothing to shift at all
	assign done = (count == 'd1) || (count == '0);

	// controller loads only once the previous shift has drained
	a_load_idle: assert property (
		@(posedge clk) disable iff (rst)
		load |-> !step
	);

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/100ps
`default_nettype none
`include "core_consts.svh"

module alu (
	input wire logic [`OP_W-1:0] op,
	input wire logic [`DATA_W-1:0] a,
	input wire logic [`DATA_W-1:0] b,
	input wire logic [`PC_W-1:0] sp_in,
	input wire logic [`IMM_W-1:0] imm,
	input wire logic [`CCR_W-1:0] flags_in,
	input wire logic shift_step,
	output logic [`DATA_W-1:0] result,
	output logic [`PC_W-1:0] sp_out,
	output logic [`CCR_W-1:0] flags_out
);
	logic [`DATA_W:0] wide;
	logic carry;
	logic keep_flags;

	always_comb begin
		wide = '0;
		carry = 1'b0;
		keep_flags = 1'b0;
		result = '0;
		sp_out = sp_in;
		case (op)
			`OP_ADD: begin
				wide = {1'b0, a} + {1'b0, b};
				result = wide[`DATA_W-1:0];
				carry = wide[`DATA_W];
			end
			`OP_SUB: begin
				// top bit set means borrow
				wide = {1'b0, a} - {1'b0, b};
				result = wide[`DATA_W-1:0];
				carry = wide[`DATA_W];
			end
			`OP_AND: result = a & b;
			`OP_OR: result = a | b;
			`OP_LDI: begin
				result = {{(`DATA_W-`IMM_W){1'b0}}, imm};
				keep_flags = 1'b1;
			end
			`OP_SHL: begin
				// one bit per step, zero amount passes a through
				result = shift_step ? {a[`DATA_W-2:0], 1'b0} : a;
				carry = shift_step & a[`DATA_W-1];
			end
			`OP_SHR: begin
				result = shift_step ? {1'b0, a[`DATA_W-1:1]} : a;
				carry = shift_step & a[0];
			end
			`OP_SPADD: begin
				// sign-extended adjust
				sp_out = sp_in + {{(`PC_W-`IMM_W){imm[`IMM_W-1]}}, imm};
				result = sp_out[`DATA_W-1:0];
				keep_flags = 1'b1;
			end
			default: keep_flags = 1'b1;
		endcase

		if (keep_flags) begin
			flags_out = flags_in;
		end else begin
			flags_out[`FLAG_Z] = (result == '0);
			flags_out[`FLAG_N] = result[`DATA_W-1];
			flags_out[`FLAG_C] = carry;
		end
	end

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/100ps
`default_nettype none
`include "core_consts.svh"

module reg_file (
	input wire logic clk,
	input wire logic rst,
	regfile_if.rf rf,
	output logic [`PC_W-1:0] pc
);
	// r0..r7, then pc low word, then pc high word
	logic [`DATA_W-1:0] regs [0:`NUM_REGS+1];
	logic [`PC_W-1:0] sp_q;
	logic [`CCR_W-1:0] ccr_q;

	// combinational reads
	// 3-bit address only reaches the general registers
	assign rf.rd1 = regs[rf.ra1];
	assign rf.rd2 = regs[rf.ra2];
	assign rf.sp = sp_q;
	assign rf.ccr = ccr_q;

	// pc rebuilt from its two halves
	assign pc = {regs[`NUM_REGS+1], regs[`NUM_REGS]};

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `NUM_REGS + 2; i++) begin
				regs[i] <= '0;
			end
			sp_q <= `SP_RESET;
			ccr_q <= '0;
		end else begin
			if (rf.we) begin
				regs[rf.waddr] <= rf.wdata;
			end
			// low half carries into high half
			if (rf.pc_inc) begin
				{regs[`NUM_REGS+1], regs[`NUM_REGS]} <= pc + 1'b1;
			end
			if (rf.sp_we) begin
				sp_q <= rf.sp_wdata;
			end
			if (rf.ccr_we) begin
				ccr_q <= rf.ccr_wdata;
			end
		end
	end

	// one retire per handshake, controller goes back to idle right after
	a_pc_inc_single: assert property (
		@(posedge clk) disable iff (rst)
		rf.pc_inc |=> !rf.pc_inc
	);

	// no write strobe ever arrives outside a retire
	a_write_with_retire: assert property (
		@(posedge clk) disable iff (rst)
		(rf.we || rf.ccr_we || rf.sp_we) |-> rf.pc_inc
	);

endmodule

`default_nettype wire

// File: hdl/regfile_if.sv
`timescale 1ns/100ps
`default_nettype none
`include "core_consts.svh"

interface regfile_if;
	// two read ports
	logic [`ADDR_W-1:0] ra1;
	logic [`ADDR_W-1:0] ra2;
	logic [`DATA_W-1:0] rd1;
	logic [`DATA_W-1:0] rd2;
	// general register write
	logic we;
	logic [`ADDR_W-1:0] waddr;
	logic [`DATA_W-1:0] wdata;
	// stack pointer
	logic sp_we;
	logic [`PC_W-1:0] sp_wdata;
	logic [`PC_W-1:0] sp;
	// condition codes
	logic ccr_we;
	logic [`CCR_W-1:0] ccr_wdata;
	logic [`CCR_W-1:0] ccr;
	// retire strobe
	logic pc_inc;

	modport ctrl (
		output ra1, ra2, we, waddr, wdata, sp_we, sp_wdata, ccr_we, ccr_wdata, pc_inc,
		input rd1, rd2, sp, ccr
	);

	modport rf (
		input ra1, ra2, we, waddr, wdata, sp_we, sp_wdata, ccr_we, ccr_wdata, pc_inc,
		output rd1, rd2, sp, ccr
	);
endinterface

`default_nettype wire

// File: hdl/core_pkg.sv
`default_nettype none
`include "core_consts.svh"

package core_pkg;

	// three-register format
	typedef struct packed {
		logic [`OP_W-1:0] opcode;
		logic [`ADDR_W-1:0] rd;
		logic [`ADDR_W-1:0] rs1;
		logic [`ADDR_W-1:0] rs2;
		logic [2:0] unused;
	} reg_view_t;

	// register plus 8-bit immediate
	typedef struct packed {
		logic [`OP_W-1:0] opcode;
		logic [`ADDR_W-1:0] rd;
		logic pad;
		logic [`IMM_W-1:0] imm;
	} imm_view_t;

	// same 16-bit word, two decodes
	typedef union packed {
		reg_view_t r;
		imm_view_t i;
	} instr_word_t;

	// controller states
	typedef enum logic [1:0] {
		IDLE,
		READ,
		EXEC,
		RESP
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath widths
`define DATA_W 16
`define ADDR_W 3
`define PC_W 32
`define CCR_W 3
`define SHAMT_W 4
`define OP_W 4
`define IMM_W 8
// general registers, pc halves sit just above them
`define NUM_REGS 8

// flag bit positions in ccr
`define FLAG_Z 0
`define FLAG_N 1
`define FLAG_C 2

// stack pointer after reset
`define SP_RESET 4095

// opcodes, anything else retires as nop
`define OP_NOP 4'd0
`define OP_ADD 4'd1
`define OP_SUB 4'd2
`define OP_AND 4'd3
`define OP_OR 4'd4
`define OP_LDI 4'd5
`define OP_SHL 4'd6
`define OP_SHR 4'd7
`define OP_SPADD 4'd8

`endif
